/* include/cpu_params.svh */
// CPU core parameters
// reset values, instruction queue depth and the debug read fallback

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////////////////////////
// reset state
////////////////////////////////////////////////////////////

`define CPU_RESET_PC 16'h8000  // first opcode fetched here
`define CPU_RESET_SP 8'hFF     // stack pointer after reset

////////////////////////////////////////////////////////////
// sizing and debug
////////////////////////////////////////////////////////////

// entries between fetch and execute, power of two
`define CPU_QUEUE_DEPTH 4

`define CPU_DBG_DEFAULT 8'hBD  // returned for unknown debug selects

`endif

/* design/cpu_pkg.sv */
// CPU core package
// opcode encodings, instruction record, flags, debug selects
// and opcode classification helpers shared by fetch and execute

package cpu_pkg;

  // kept subset, 6502 encodings
  typedef enum logic [7:0] {
    and_imm = 8'h29,
    and_zp  = 8'h25,
    cmp_imm = 8'hC9,
    cmp_zp  = 8'hC5,
    eor_imm = 8'h49,
    eor_zp  = 8'h45,
    lda_imm = 8'hA9,
    lda_zp  = 8'hA5,
    ldx_imm = 8'hA2,
    ldx_zp  = 8'hA6,
    ldy_imm = 8'hA0,
    ldy_zp  = 8'hA4,
    nop     = 8'hEA,
    ora_imm = 8'h09,
    ora_zp  = 8'h05,
    sta_zp  = 8'h85,
    stx_zp  = 8'h86,
    sty_zp  = 8'h84,
    tax     = 8'hAA,
    tay     = 8'hA8,
    tsx     = 8'hBA,
    txa     = 8'h8A,
    txs     = 8'h9A,
    tya     = 8'h98
  } opcode_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [7:0] operand;  // zero for one-byte instructions
  } instr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
  } flags_t;

  typedef enum logic [3:0] {
    dbg_pcl = 4'd0,
    dbg_pch = 4'd1,
    dbg_ac  = 4'd2,
    dbg_x   = 4'd3,
    dbg_y   = 4'd4,
    dbg_p   = 4'd5,
    dbg_s   = 4'd6
  } dbg_sel_t;

  // bytes per instruction, unknown opcodes count as one byte
  function automatic logic [1:0] instr_len(input opcode_t op);
    case (op)
      and_imm, and_zp, cmp_imm, cmp_zp, eor_imm, eor_zp, ora_imm, ora_zp,
      lda_imm, lda_zp, ldx_imm, ldx_zp, ldy_imm, ldy_zp,
      sta_zp, stx_zp, sty_zp:
        return 2'd2;
      default:
        return 2'd1;
    endcase
  endfunction

  // zero-page loads and logic/compare reads
  function automatic logic is_zp_read(input opcode_t op);
    case (op)
      lda_zp, ldx_zp, ldy_zp, and_zp, ora_zp, eor_zp, cmp_zp:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

endpackage

/* design/instr_fifo.sv */
// Instruction queue
// circular FIFO of instruction records between fetch and execute,
// valid/ready on both sides, full queue takes a push only with a pop

module instr_fifo #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            push_valid,
  input  cpu_pkg::instr_t push_item,
  output logic            push_ready,
  output logic            pop_valid,
  output cpu_pkg::instr_t pop_item,
  input  logic            pop_ready
);
  import cpu_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  instr_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          push_fire;
  logic          pop_fire;

  assign full       = (count == (AW + 1)'(DEPTH));
  assign pop_valid  = (count != '0);
  assign pop_item   = mem[rd_ptr];
  assign push_ready = !full || pop_ready;  // slot frees on the same edge
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  always_ff @(posedge clk)
  begin
    if (push_fire)
      mem[wr_ptr] <= push_item;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_fire)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_fire)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // never more entries than slots
  assert property (@(posedge clk) disable iff (rst)
    count <= (AW + 1)'(DEPTH));
  // pointer distance tracks the count
  assert property (@(posedge clk) disable iff (rst)
    wr_ptr - rd_ptr == AW'(count % DEPTH));

endmodule

/* design/cpu_fetch.sv */
// Instruction fetch
// walks the program port and packs opcode plus operand into
// instruction records, one byte per cycle, stalls on back-pressure

`include "cpu_params.svh"

module cpu_fetch (
  input  logic            clk,
  input  logic            rst,
  output logic [15:0]     prog_addr,
  input  logic [7:0]      prog_data,
  output logic            push_valid,
  output cpu_pkg::instr_t push_item,
  input  logic            push_ready
);
  import cpu_pkg::*;

  logic [15:0] pc;
  logic        have_op;   // opcode captured, awaiting operand
  opcode_t     op_q;      // captured opcode byte
  opcode_t     cur_op;
  logic        two_byte;
  logic        take_byte; // byte on prog_data consumed this cycle

  assign prog_addr = pc;
  assign cur_op    = opcode_t'(prog_data);
  assign two_byte  = (instr_len(cur_op) == 2'd2);

  ////////////////////////////////////////////////////////////
  // record assembly
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    if (have_op)
    begin
      push_valid = 1'b1;  // operand byte completes the record
      push_item  = '{opcode: op_q, operand: prog_data};
    end
    else
    begin
      push_valid = !two_byte;
      push_item  = '{opcode: cur_op, operand: 8'h00};
    end
  end

  // opcode of a two-byte instruction is taken without a handshake
  assign take_byte = !push_valid || push_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc      <= `CPU_RESET_PC;
      have_op <= 1'b0;
    end
    else if (take_byte)
    begin
      pc      <= pc + 16'd1;
      have_op <= !have_op && two_byte;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!have_op)
      op_q <= cur_op;
  end

  // a stalled record must not change until the queue takes it
  assert property (@(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> push_valid && $stable(push_item));

endmodule

/* design/cpu_execute.sv */
// Execute stage
// register file, N/Z/C flags and ALU for the kept subset, plus the
// four-phase sequencer for zero-page reads and writes

`include "cpu_params.svh"

module cpu_execute (
  input  logic              clk,
  input  logic              rst,
  input  logic              pop_valid,
  input  cpu_pkg::instr_t   pop_item,
  output logic              pop_ready,
  output logic              mem_req,
  output logic              mem_we,
  output logic [7:0]        mem_addr,
  output logic [7:0]        mem_wdata,
  input  logic              mem_ack,
  input  logic [7:0]        mem_rdata,
  input  cpu_pkg::dbg_sel_t dbg_sel,
  input  logic [15:0]       dbg_pc,
  output logic [7:0]        dbg_data
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {idle, bus_req, bus_wait_low} seq_t;

  seq_t       state;
  logic [7:0] reg_a;
  logic [7:0] reg_x;
  logic [7:0] reg_y;
  logic [7:0] reg_s;
  flags_t     flags;
  opcode_t    op_q;       // opcode of the open bus cycle
  logic       pop_fire;
  logic       is_read;
  logic       is_store;
  logic [7:0] store_data;
  logic       retire;     // result written this edge
  opcode_t    ret_op;
  logic [7:0] ret_val;    // immediate or read data
  logic [8:0] cmp_sum;
  logic [7:0] res;
  logic       set_nz;
  logic [7:0] a_nxt;
  logic [7:0] x_nxt;
  logic [7:0] y_nxt;
  logic [7:0] s_nxt;
  flags_t     flags_nxt;

  assign pop_ready = (state == idle);
  assign pop_fire  = pop_valid && pop_ready;
  assign mem_req   = (state == bus_req);
  assign is_read   = is_zp_read(pop_item.opcode);
  assign is_store  = pop_item.opcode inside {sta_zp, stx_zp, sty_zp};

  always_comb
  begin
    case (pop_item.opcode)
      stx_zp:  store_data = reg_x;
      sty_zp:  store_data = reg_y;
      default: store_data = reg_a;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // ALU and register update
  ////////////////////////////////////////////////////////////

  assign retire  = (pop_fire && !is_read && !is_store) ||
                   (state == bus_req && mem_ack && !mem_we);
  assign ret_op  = (state == idle) ? pop_item.opcode : op_q;
  assign ret_val = (state == idle) ? pop_item.operand : mem_rdata;
  assign cmp_sum = {1'b0, reg_a} + {1'b0, ~ret_val} + 9'd1;  // carry out means A >= M

  always_comb
  begin
    a_nxt     = reg_a;
    x_nxt     = reg_x;
    y_nxt     = reg_y;
    s_nxt     = reg_s;
    flags_nxt = flags;
    res       = 8'h00;
    set_nz    = retire;
    if (retire)
    begin
      case (ret_op)
        lda_imm, lda_zp: a_nxt = ret_val;
        ldx_imm, ldx_zp: x_nxt = ret_val;
        ldy_imm, ldy_zp: y_nxt = ret_val;
        and_imm, and_zp: a_nxt = reg_a & ret_val;
        ora_imm, ora_zp: a_nxt = reg_a | ret_val;
        eor_imm, eor_zp: a_nxt = reg_a ^ ret_val;
        tax:             x_nxt = reg_a;
        tay:             y_nxt = reg_a;
        tsx:             x_nxt = reg_s;
        txa:             a_nxt = reg_x;
        tya:             a_nxt = reg_y;
        cmp_imm, cmp_zp: flags_nxt.c = cmp_sum[8];
        txs:
        begin
          s_nxt  = reg_x;  // no flag change
          set_nz = 1'b0;
        end
        default: set_nz = 1'b0;  // nop and unknown opcodes
      endcase
      case (ret_op)
        ldx_imm, ldx_zp, tax, tsx: res = x_nxt;
        ldy_imm, ldy_zp, tay:      res = y_nxt;
        cmp_imm, cmp_zp:           res = cmp_sum[7:0];
        default:                   res = a_nxt;
      endcase
      if (set_nz)
      begin
        flags_nxt.n = res[7];
        flags_nxt.z = (res == 8'h00);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reg_a <= 8'h00;
      reg_x <= 8'h00;
      reg_y <= 8'h00;
      reg_s <= `CPU_RESET_SP;
      flags <= '0;
    end
    else
    begin
      reg_a <= a_nxt;
      reg_x <= x_nxt;
      reg_y <= y_nxt;
      reg_s <= s_nxt;
      flags <= flags_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // zero-page bus sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= idle;
      mem_we <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
          if (pop_fire && (is_read || is_store))
          begin
            state  <= bus_req;
            mem_we <= is_store;
          end
        bus_req:
          if (mem_ack)
            state <= bus_wait_low;  // req drops next cycle
        bus_wait_low:
          if (!mem_ack)
            state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop_fire)
    begin
      mem_addr  <= pop_item.operand;
      mem_wdata <= store_data;
      op_q      <= pop_item.opcode;
    end
  end

  // debug read, P packs as n, five zeros, z, c
  always_comb
  begin
    case (dbg_sel)
      dbg_pcl: dbg_data = dbg_pc[7:0];
      dbg_pch: dbg_data = dbg_pc[15:8];
      dbg_ac:  dbg_data = reg_a;
      dbg_x:   dbg_data = reg_x;
      dbg_y:   dbg_data = reg_y;
      dbg_p:   dbg_data = {flags.n, 5'b00000, flags.z, flags.c};
      dbg_s:   dbg_data = reg_s;
      default: dbg_data = `CPU_DBG_DEFAULT;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst)
    mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_wdata)));
  assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_ack |=> mem_req);

endmodule

/* design/cpu_top.sv */
// CPU core top level
// fetch, instruction queue and execute joined by valid/ready links,
// program port toward the ROM and zero-page data port toward memory

`include "cpu_params.svh"

module cpu_top (
  input  logic              clk,
  input  logic              rst,
  output logic [15:0]       prog_addr,
  input  logic [7:0]        prog_data,
  output logic              mem_req,
  output logic              mem_we,
  output logic [7:0]        mem_addr,
  output logic [7:0]        mem_wdata,
  input  logic              mem_ack,
  input  logic [7:0]        mem_rdata,
  input  cpu_pkg::dbg_sel_t dbg_sel,
  output logic [7:0]        dbg_data
);
  import cpu_pkg::*;

  logic   push_valid;
  logic   push_ready;
  instr_t push_item;
  logic   pop_valid;
  logic   pop_ready;
  instr_t pop_item;

  cpu_fetch fetch_i (
    .clk        (clk),
    .rst        (rst),
    .prog_addr  (prog_addr),
    .prog_data  (prog_data),
    .push_valid (push_valid),
    .push_item  (push_item),
    .push_ready (push_ready)
  );

  instr_fifo #(
    .DEPTH (`CPU_QUEUE_DEPTH)
  ) queue_i (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_item  (push_item),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_item   (pop_item),
    .pop_ready  (pop_ready)
  );

  cpu_execute execute_i (
    .clk       (clk),
    .rst       (rst),
    .pop_valid (pop_valid),
    .pop_item  (pop_item),
    .pop_ready (pop_ready),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .dbg_sel   (dbg_sel),
    .dbg_pc    (prog_addr),  // fetch PC for the PCL/PCH selects
    .dbg_data  (dbg_data)
  );

endmodule

/* dv/cpu_tb.sv */
// CPU core testbench
// program ROM, zero-page memory with random ack delays, an ISA
// reference model and assertions on the bus, fetch and debug ports

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_pkg::*;

  typedef struct packed {
    logic       we;
    logic [7:0] addr;
    logic [7:0] data;  // store data, zero for reads
  } bus_event_t;

  localparam logic [15:0] rom_base = 16'h8000;
  localparam int prog_len = 60;
  localparam int wait_limit = 200;  // cycles per wait

  // three NOPs first so the reset state can be read out
  localparam logic [7:0] prog_bytes [prog_len] = '{
    8'hEA, 8'hEA, 8'hEA,
    8'hA9, 8'h81, 8'h85, 8'h10, 8'hA6, 8'h20, 8'hA0, 8'h00, 8'h86, 8'h11, 8'h84, 8'h12,
    8'hA5, 8'h21, 8'h29, 8'hF0, 8'h05, 8'h22, 8'h49, 8'h5A, 8'h85, 8'h13,
    8'h25, 8'h23, 8'h09, 8'h0C, 8'h45, 8'h24, 8'h85, 8'h14,
    8'hA4, 8'h25, 8'h98, 8'hAA, 8'h86, 8'h15,
    8'hA9, 8'h3C, 8'hA8, 8'h84, 8'h16,
    8'hA2, 8'h40, 8'h9A, 8'hA2, 8'h00, 8'hBA, 8'h8A, 8'h85, 8'h17,
    8'hEA, 8'hC5, 8'h26, 8'hC9, 8'h40, 8'h85, 8'h18
  };

  logic        clk;
  logic        rst;
  logic [15:0] prog_addr;
  logic [7:0]  prog_data;
  logic        mem_req;
  logic        mem_we;
  logic [7:0]  mem_addr;
  logic [7:0]  mem_wdata;
  logic        mem_ack;
  logic [7:0]  mem_rdata;
  dbg_sel_t    dbg_sel;
  logic [7:0]  dbg_data;

  logic [31:0] lfsr = 32'h7906;
  logic [7:0]  zp_mem [256];
  logic [7:0]  ref_mem [256];
  bus_event_t  exp_q [$];  // bus events in program order
  logic [7:0]  ref_a;
  logic [7:0]  ref_x;
  logic [7:0]  ref_y;
  logic [7:0]  ref_s;
  logic [7:0]  ref_p;

  cpu_top cpu_top_i (
    .clk       (clk),
    .rst       (rst),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .dbg_sel   (dbg_sel),
    .dbg_data  (dbg_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [7:0] rom_read(input logic [15:0] addr);
    int offset;
    offset = int'(addr - rom_base);
    if (offset < prog_len)
      return prog_bytes[offset];
    return 8'hEA;  // NOPs past the program
  endfunction

  assign prog_data = rom_read(prog_addr);

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [7:0] value);
    value = 8'h00;
    for (int k = 0; k < count; k++)
    begin
      lfsr  = lfsr_next(lfsr);
      value = {value[6:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] expected);
    $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, expected);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("%0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  task automatic build_expected();
    logic [7:0] op;
    logic [7:0] opnd;
    logic [7:0] v;
    logic [7:0] r;
    logic       n;
    logic       z;
    logic       c;
    logic       nz;
    int         i;
    int         len;
    {n, z, c} = 3'b000;
    {ref_a, ref_x, ref_y} = 24'h0;
    ref_s = 8'hFF;
    i = 0;
    while (i < prog_len)
    begin
      op   = prog_bytes[i];
      opnd = (i + 1 < prog_len) ? prog_bytes[i + 1] : 8'h00;
      v    = opnd;
      r    = 8'h00;
      nz   = 1'b1;
      len  = 2;
      case (op)  // zero-page operand fetch
        8'hA5, 8'hA6, 8'hA4, 8'h25, 8'h05, 8'h45, 8'hC5:
        begin
          v = ref_mem[opnd];
          exp_q.push_back('{we: 1'b0, addr: opnd, data: 8'h00});
        end
        default: ;
      endcase
      case (op)
        8'hA9, 8'hA5:
        begin
          ref_a = v;
          r     = v;
        end
        8'hA2, 8'hA6:
        begin
          ref_x = v;
          r     = v;
        end
        8'hA0, 8'hA4:
        begin
          ref_y = v;
          r     = v;
        end
        8'h29, 8'h25:
        begin
          ref_a = ref_a & v;
          r     = ref_a;
        end
        8'h09, 8'h05:
        begin
          ref_a = ref_a | v;
          r     = ref_a;
        end
        8'h49, 8'h45:
        begin
          ref_a = ref_a ^ v;
          r     = ref_a;
        end
        8'hC9, 8'hC5:
        begin
          r = ref_a - v;
          c = (ref_a >= v);
        end
        8'h85, 8'h86, 8'h84:
        begin
          v  = (op == 8'h85) ? ref_a : (op == 8'h86) ? ref_x : ref_y;
          nz = 1'b0;
          ref_mem[opnd] = v;
          exp_q.push_back('{we: 1'b1, addr: opnd, data: v});
        end
        8'hAA:
        begin
          ref_x = ref_a;
          r     = ref_x;
          len   = 1;
        end
        8'hA8:
        begin
          ref_y = ref_a;
          r     = ref_y;
          len   = 1;
        end
        8'h8A:
        begin
          ref_a = ref_x;
          r     = ref_a;
          len   = 1;
        end
        8'h98:
        begin
          ref_a = ref_y;
          r     = ref_a;
          len   = 1;
        end
        8'hBA:
        begin
          ref_x = ref_s;
          r     = ref_x;
          len   = 1;
        end
        8'h9A:
        begin
          ref_s = ref_x;
          nz    = 1'b0;
          len   = 1;
        end
        default:  // NOP
        begin
          nz  = 1'b0;
          len = 1;
        end
      endcase
      if (nz)
      begin
        n = r[7];
        z = (r == 8'h00);
      end
      i += len;
    end
    ref_p = {n, 5'b00000, z, c};
  endtask

  ////////////////////////////////////////////////////////////
  // memory side of the handshake
  ////////////////////////////////////////////////////////////

  task automatic wait_req(input logic level);
    int cycles;
    cycles = 0;
    while (mem_req !== level)
    begin
      if (cycles == wait_limit)
        abort_run($sformatf("timeout waiting for mem_req to be %0b", level));
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic serve_bus();
    bus_event_t ev;
    logic [7:0] delay;
    while (exp_q.size() > 0)
    begin
      ev = exp_q.pop_front();
      wait_req(1'b1);
      assert (mem_we == ev.we) else report_mismatch("mem_we", mem_we, ev.we);
      assert (mem_addr == ev.addr) else report_mismatch("mem_addr", mem_addr, ev.addr);
      if (ev.we)
      begin
        assert (mem_wdata == ev.data) else report_mismatch("mem_wdata", mem_wdata, ev.data);
      end
      draw_bits(3, delay);  // 0 to 7 idle cycles
      repeat (delay) @(negedge clk);
      if (mem_we)
        zp_mem[mem_addr] = mem_wdata;
      else
        mem_rdata = zp_mem[mem_addr];
      mem_ack = 1'b1;
      @(negedge clk);
      wait_req(1'b0);
      draw_bits(2, delay);  // ack lingers 0 to 3 cycles after req falls
      repeat (delay) @(negedge clk);
      mem_ack = 1'b0;
    end
  endtask

  // select on one falling edge, sample on the next
  task automatic check_dbg(input dbg_sel_t sel, input string name,
                           input logic [7:0] expected);
    dbg_sel = sel;
    @(negedge clk);
    assert (dbg_data == expected) else report_mismatch(name, dbg_data, expected);
  endtask

  assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req)
    else abort_run("mem_req fell before mem_ack");
  assert property (@(posedge clk) disable iff (rst)
    mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_wdata) && $stable(mem_we)))
    else abort_run("mem_addr, mem_wdata or mem_we changed while mem_req was high");
  assert property (@(posedge clk) disable iff (rst) !mem_req && mem_ack |=> !mem_req)
    else abort_run("mem_req rose again while mem_ack was still high");
  assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> prog_addr == $past(prog_addr) || prog_addr == $past(prog_addr) + 16'd1)
    else abort_run("prog_addr moved by more than one in a cycle");

  initial
  begin
    logic [7:0] fill;
    rst       = 1'b1;
    mem_ack   = 1'b0;
    mem_rdata = 8'h00;
    dbg_sel   = dbg_ac;
    for (int a = 0; a < 256; a++)
    begin
      draw_bits(8, fill);
      zp_mem[a]  = fill;
      ref_mem[a] = fill;
    end
    build_expected();

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (mem_req == 1'b0) else report_mismatch("mem_req", mem_req, 8'h00);
    assert (prog_addr == rom_base) else report_mismatch("prog_addr", prog_addr, rom_base);
    check_dbg(dbg_ac, "dbg A", 8'h00);
    check_dbg(dbg_x, "dbg X", 8'h00);
    check_dbg(dbg_y, "dbg Y", 8'h00);
    check_dbg(dbg_s, "dbg S", 8'hFF);

    serve_bus();

    // last store done, only NOPs follow
    check_dbg(dbg_ac, "dbg A", ref_a);
    check_dbg(dbg_x, "dbg X", ref_x);
    check_dbg(dbg_y, "dbg Y", ref_y);
    check_dbg(dbg_s, "dbg S", ref_s);
    check_dbg(dbg_p, "dbg P", ref_p);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
design/cpu_pkg.sv
design/instr_fifo.sv
design/cpu_fetch.sv
design/cpu_execute.sv
design/cpu_top.sv
dv/cpu_tb.sv
